// File: prbs_emu_params.svh
`ifndef PRBS_EMU_PARAMS_SVH
`define PRBS_EMU_PARAMS_SVH

////////////////////
// Lane bank sizing
////////////////////

// Interleaved lanes, one bit each per word
`define NTI 16

// LFSR length of every lane
`define PRBS_N 32

// Lanes step once every NUM_CHUNKS+2 emulator cycles
`define NUM_CHUNKS 4

////////////////////
// Dump memory
////////////////////

`define DUMP_DEPTH 32
`define DUMP_AW 5

`endif

// File: prbs_emu_pkg.sv
`default_nettype none

`include "prbs_emu_params.svh"

package prbs_emu_pkg;

    // One word of the stream, bit i comes from lane i
    typedef logic [`NTI-1:0] lane_word_t;

    // Output polarity shared by all lanes
    typedef enum logic {
        POL_NORMAL = 1'b0,
        POL_INVERT = 1'b1
    } polarity_e;

    // Dump capture FSM
    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,
        CAP_FILL = 2'd1,
        CAP_DONE = 2'd2
    } cap_state_e;

    // Request from a peer toward the arbiter
    typedef struct packed {
        logic                req;
        logic                we;
        logic [`DUMP_AW-1:0] addr;
        lane_word_t          wdata;
    } sram_req_t;

    // Arbitrated SRAM access
    typedef struct packed {
        logic                en;
        logic                we;
        logic [`DUMP_AW-1:0] addr;
        lane_word_t          wdata;
    } sram_port_t;

endpackage

`default_nettype wire

// File: prbs_lane_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module prbs_lane_gen (
    input  wire logic                    emu_clk,
    input  wire logic                    emu_rst,
    input  wire logic                    cke_i,
    input  wire logic [`PRBS_N-1:0]      seed_i,
    input  wire logic [`PRBS_N-1:0]      eqn_i,
    input  wire logic                    inj_err_i,
    input  wire prbs_emu_pkg::polarity_e polarity_i,
    output logic                         bit_o
);

    ////////////////////
    // LFSR state
    ////////////////////

    logic [`PRBS_N-1:0] state_q;
    logic               fb_bit;
    logic               raw_bit;
    logic               inv_bit;

    // Parity of the taps selected by the equation
    assign fb_bit = ^(state_q & eqn_i);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q <= seed_i;
        end else if (cke_i) begin
            // Shift toward the MSB, feedback enters at bit 0
            state_q <= {state_q[`PRBS_N-2:0], fb_bit};
        end
    end

    ////////////////////
    // Output modifiers
    ////////////////////

    // Lane bit is the MSB of the current state
    assign raw_bit = state_q[`PRBS_N-1];

    assign inv_bit = (polarity_i == prbs_emu_pkg::POL_INVERT);

    // Injection and polarity only touch the output, never the state
    assign bit_o = raw_bit ^ inj_err_i ^ inv_bit;

endmodule

`default_nettype wire

// File: prbs_source_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module prbs_source_bank (
    input  wire logic                             emu_clk,
    input  wire logic                             emu_rst,
    input  wire logic [`NTI-1:0][`PRBS_N-1:0]     seeds_i,
    input  wire logic [`PRBS_N-1:0]               eqn_i,
    input  wire prbs_emu_pkg::lane_word_t         inj_mask_i,
    input  wire prbs_emu_pkg::polarity_e          polarity_i,
    output prbs_emu_pkg::lane_word_t              word_o,
    output logic                                  word_stb_o
);

    ////////////////////
    // Enable pacer
    ////////////////////

    localparam int unsigned cnt_w = $clog2(`NUM_CHUNKS + 2);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`NUM_CHUNKS + 1);

    logic [cnt_w-1:0] cnt_q;
    logic             prbs_cke;

    // One enable per NUM_CHUNKS+2 cycles
    assign prbs_cke = (cnt_q == cnt_last);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cnt_q <= '0;
        end else if (prbs_cke) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign word_stb_o = prbs_cke;

    ////////////////////
    // Lane generators
    ////////////////////

    for (genvar i = 0; i < `NTI; i++) begin : g_lane
        prbs_lane_gen u_lane (
            .emu_clk    (emu_clk),
            .emu_rst    (emu_rst),
            .cke_i      (prbs_cke),
            .seed_i     (seeds_i[i]),
            .eqn_i      (eqn_i),
            .inj_err_i  (inj_mask_i[i]),
            .polarity_i (polarity_i),
            .bit_o      (word_o[i])
        );
    end

endmodule

`default_nettype wire

// File: dump_capture.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module dump_capture (
    input  wire logic                     emu_clk,
    input  wire logic                     emu_rst,
    input  wire logic                     dump_start_i,
    input  wire prbs_emu_pkg::lane_word_t word_i,
    input  wire logic                     word_stb_i,
    output prbs_emu_pkg::sram_req_t       cap_req_o,
    output logic                          dump_done_o
);

    localparam logic [`DUMP_AW-1:0] last_addr = `DUMP_AW'(`DUMP_DEPTH - 1);

    prbs_emu_pkg::cap_state_e state_q;
    logic [`DUMP_AW-1:0]      wr_addr_q;
    logic                     cap_wr;

    ////////////////////
    // Capture FSM
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q   <= prbs_emu_pkg::CAP_IDLE;
            wr_addr_q <= '0;
        end else begin
            case (state_q)
                prbs_emu_pkg::CAP_IDLE: begin
                    // Starts are only honoured here
                    if (dump_start_i) begin
                        state_q   <= prbs_emu_pkg::CAP_FILL;
                        wr_addr_q <= '0;
                    end
                end
                prbs_emu_pkg::CAP_FILL: begin
                    if (word_stb_i) begin
                        if (wr_addr_q == last_addr) begin
                            state_q <= prbs_emu_pkg::CAP_DONE;
                        end else begin
                            wr_addr_q <= wr_addr_q + 1'b1;
                        end
                    end
                end
                prbs_emu_pkg::CAP_DONE: begin
                    // Sticky until reset
                    state_q <= prbs_emu_pkg::CAP_DONE;
                end
                default: begin
                    state_q <= prbs_emu_pkg::CAP_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Write request
    ////////////////////

    // Single cycle request on each strobe while filling
    assign cap_wr = (state_q == prbs_emu_pkg::CAP_FILL) && word_stb_i;

    assign cap_req_o.req   = cap_wr;
    assign cap_req_o.we    = cap_wr;
    assign cap_req_o.addr  = wr_addr_q;
    assign cap_req_o.wdata = word_i;

    assign dump_done_o = (state_q == prbs_emu_pkg::CAP_DONE);

endmodule

`default_nettype wire

// File: dump_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module dump_reader (
    input  wire logic                     emu_clk,
    input  wire logic                     emu_rst,
    input  wire logic                     rd_stb_i,
    input  wire logic [`DUMP_AW-1:0]      rd_addr_i,
    input  wire logic                     gnt_i,
    input  wire prbs_emu_pkg::lane_word_t sram_rdata_i,
    output prbs_emu_pkg::sram_req_t       rd_req_o,
    output logic                          rd_valid_o,
    output prbs_emu_pkg::lane_word_t      rd_data_o
);

    logic                pend_q;
    logic [`DUMP_AW-1:0] pend_addr_q;
    logic                new_rd;

    ////////////////////
    // Pending request
    ////////////////////

    // Strobes are dropped while an earlier read is outstanding
    assign new_rd = rd_stb_i && !pend_q;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            pend_q <= 1'b0;
        end else if (gnt_i) begin
            pend_q <= 1'b0;
        end else if (new_rd) begin
            pend_q <= 1'b1;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (new_rd) begin
            pend_addr_q <= rd_addr_i;
        end
    end

    // A fresh strobe requests in its own cycle, the latch covers a lost slot
    assign rd_req_o.req   = pend_q || rd_stb_i;
    assign rd_req_o.we    = 1'b0;
    assign rd_req_o.addr  = pend_q ? pend_addr_q : rd_addr_i;
    assign rd_req_o.wdata = '0;

    ////////////////////
    // Read return
    ////////////////////

    // Grant marks SRAM data on its output, return it one cycle later
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= gnt_i;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (gnt_i) begin
            rd_data_o <= sram_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: sram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sram_arbiter (
    input  wire logic                    emu_clk,
    input  wire logic                    emu_rst,
    input  wire prbs_emu_pkg::sram_req_t cap_req_i,
    input  wire prbs_emu_pkg::sram_req_t rd_req_i,
    output logic                         rd_gnt_o,
    output prbs_emu_pkg::sram_port_t     sram_o
);

    logic                    cap_win;
    logic                    rd_win;
    logic                    rd_gnt_q;
    prbs_emu_pkg::sram_req_t win_req;

    ////////////////////
    // Fixed priority
    ////////////////////

    // Capture always wins its slot
    assign cap_win = cap_req_i.req;

    // Reader is held off in the cycle its previous grant is returned
    assign rd_win = rd_req_i.req && !cap_req_i.req && !rd_gnt_q;

    assign win_req = cap_win ? cap_req_i : rd_req_i;

    ////////////////////
    // SRAM port
    ////////////////////

    always_comb begin
        sram_o.en    = cap_win || rd_win;
        sram_o.we    = (cap_win || rd_win) && win_req.we;
        sram_o.addr  = win_req.addr;
        sram_o.wdata = win_req.wdata;
    end

    ////////////////////
    // Grant owner
    ////////////////////

    // High while the reader's data sits on the SRAM output
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            rd_gnt_q <= 1'b0;
        end else begin
            rd_gnt_q <= rd_win;
        end
    end

    assign rd_gnt_o = rd_gnt_q;

endmodule

`default_nettype wire

// File: dump_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module dump_sram (
    input  wire logic                     emu_clk,
    input  wire prbs_emu_pkg::sram_port_t port_i,
    output prbs_emu_pkg::lane_word_t      rdata_o
);

    prbs_emu_pkg::lane_word_t mem [`DUMP_DEPTH];

    ////////////////////
    // Single port
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end else begin
                // Read data valid the cycle after the access
                rdata_o <= mem[port_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: prbs_emu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module prbs_emu_top (
    input  wire logic                         emu_clk,
    input  wire logic                         emu_rst,
    input  wire logic [`NTI-1:0][`PRBS_N-1:0] seeds_i,
    input  wire logic [`PRBS_N-1:0]           eqn_i,
    input  wire prbs_emu_pkg::lane_word_t     inj_mask_i,
    input  wire prbs_emu_pkg::polarity_e      polarity_i,
    input  wire logic                         dump_start_i,
    output logic                              dump_done_o,
    input  wire logic                         rd_stb_i,
    input  wire logic [`DUMP_AW-1:0]          rd_addr_i,
    output logic                              rd_valid_o,
    output prbs_emu_pkg::lane_word_t          rd_data_o,
    output prbs_emu_pkg::lane_word_t          word_o,
    output logic                              word_stb_o
);

    prbs_emu_pkg::sram_req_t  cap_req;
    prbs_emu_pkg::sram_req_t  rd_req;
    prbs_emu_pkg::sram_port_t sram_port;
    prbs_emu_pkg::lane_word_t sram_rdata;
    logic                     rd_gnt;

    ////////////////////
    // Stimulus
    ////////////////////

    prbs_source_bank u_bank (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .seeds_i    (seeds_i),
        .eqn_i      (eqn_i),
        .inj_mask_i (inj_mask_i),
        .polarity_i (polarity_i),
        .word_o     (word_o),
        .word_stb_o (word_stb_o)
    );

    ////////////////////
    // Dump path
    ////////////////////

    dump_capture u_capture (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .dump_start_i (dump_start_i),
        .word_i       (word_o),
        .word_stb_i   (word_stb_o),
        .cap_req_o    (cap_req),
        .dump_done_o  (dump_done_o)
    );

    dump_reader u_reader (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .rd_stb_i     (rd_stb_i),
        .rd_addr_i    (rd_addr_i),
        .gnt_i        (rd_gnt),
        .sram_rdata_i (sram_rdata),
        .rd_req_o     (rd_req),
        .rd_valid_o   (rd_valid_o),
        .rd_data_o    (rd_data_o)
    );

    sram_arbiter u_arbiter (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .cap_req_i (cap_req),
        .rd_req_i  (rd_req),
        .rd_gnt_o  (rd_gnt),
        .sram_o    (sram_port)
    );

    dump_sram u_sram (
        .emu_clk (emu_clk),
        .port_i  (sram_port),
        .rdata_o (sram_rdata)
    );

endmodule

`default_nettype wire

// File: tb_prbs_emu.sv
`timescale 1ns/1ns
`default_nettype none

`include "prbs_emu_params.svh"

module tb_prbs_emu;

    logic                         emu_clk;
    logic                         emu_rst;
    logic [`NTI-1:0][`PRBS_N-1:0] seeds_i;
    logic [`PRBS_N-1:0]           eqn_i;
    prbs_emu_pkg::lane_word_t     inj_mask_i;
    prbs_emu_pkg::polarity_e      polarity_i;
    logic                         dump_start_i;
    logic                         dump_done_o;
    logic                         rd_stb_i;
    logic [`DUMP_AW-1:0]          rd_addr_i;
    logic                         rd_valid_o;
    prbs_emu_pkg::lane_word_t     rd_data_o;
    prbs_emu_pkg::lane_word_t     word_o;
    logic                         word_stb_o;

    // Trace contents
    logic [`PRBS_N-1:0] seed_val [`NTI];
    string              op_q [$];
    int                 arg0_q [$];
    int                 arg1_q [$];
    int                 arg2_q [$];

    // Reference model
    logic [`PRBS_N-1:0]        model_q [`NTI];
    prbs_emu_pkg::lane_word_t  dump_exp [`DUMP_DEPTH];
    prbs_emu_pkg::lane_word_t  exp_word;
    prbs_emu_pkg::cap_state_e  cap_state;
    int                        dump_cnt;
    int                        stb_gap;
    int                        cycle_cnt = 0;
    int                        cycle_limit = 100000;

    prbs_emu_top u_dut (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .seeds_i      (seeds_i),
        .eqn_i        (eqn_i),
        .inj_mask_i   (inj_mask_i),
        .polarity_i   (polarity_i),
        .dump_start_i (dump_start_i),
        .dump_done_o  (dump_done_o),
        .rd_stb_i     (rd_stb_i),
        .rd_addr_i    (rd_addr_i),
        .rd_valid_o   (rd_valid_o),
        .rd_data_o    (rd_data_o),
        .word_o       (word_o),
        .word_stb_o   (word_stb_o)
    );

    initial begin
        emu_clk = 1'b0;
        forever #5 emu_clk = ~emu_clk;
    end

    ////////////////////
    // Failure handling
    ////////////////////

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    // Hung run guard
    always @(posedge emu_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    ////////////////////
    // Trace loading
    ////////////////////

    task automatic load_trace();
        int    fd;
        int    n;
        int    a0;
        int    a1;
        int    a2;
        int    total;
        string line;
        string op;
        total = 10;
        fd = $fopen("prbs_emu_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file prbs_emu_trace.txt");
            stop_on_failure();
        end
        while ($fgets(line, fd) > 0) begin
            op = "";
            a0 = 0;
            a1 = 0;
            a2 = 0;
            n = $sscanf(line, "%s", op);
            if (n < 1 || op.getc(0) == "#") begin
                continue;
            end
            if (op == "eqn" || op == "mask") begin
                n = $sscanf(line, "%s %h", op, a0);
            end else if (op == "seed") begin
                n = $sscanf(line, "%s %d %h", op, a0, a1);
            end else begin
                n = $sscanf(line, "%s %d %d %d", op, a0, a1, a2);
            end
            if (op == "eqn") begin
                eqn_i <= `PRBS_N'(a0);
            end else if (op == "seed") begin
                seed_val[a0] = `PRBS_N'(a1);
            end else begin
                op_q.push_back(op);
                arg0_q.push_back(a0);
                arg1_q.push_back(a1);
                arg2_q.push_back(a2);
                if (op == "wait") total += a0;
                if (op == "read") total += a1 * (`NUM_CHUNKS + 10);
            end
        end
        $fclose(fd);
        cycle_limit = 2 * total + 100;
    endtask

    ////////////////////
    // Stream monitor and model
    ////////////////////

    always @(negedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < `NTI; i++) begin
                model_q[i] = seed_val[i];
            end
            cap_state = prbs_emu_pkg::CAP_IDLE;
            dump_cnt  = 0;
            stb_gap   = 0;
        end else begin
            stb_gap++;
            check_value("dump_done_o", 32'(dump_done_o),
                        32'(cap_state == prbs_emu_pkg::CAP_DONE));
            if (word_stb_o) begin
                check_value("word_stb_o interval", stb_gap, `NUM_CHUNKS + 2);
                stb_gap = 0;
                // Lane output is the MSB before the step
                for (int i = 0; i < `NTI; i++) begin
                    exp_word[i] = model_q[i][`PRBS_N-1];
                end
                exp_word = exp_word ^ inj_mask_i
                         ^ {`NTI{polarity_i == prbs_emu_pkg::POL_INVERT}};
                check_value("word_o", 32'(word_o), 32'(exp_word));
                if (cap_state == prbs_emu_pkg::CAP_FILL) begin
                    dump_exp[dump_cnt] = exp_word;
                    dump_cnt++;
                    if (dump_cnt == `DUMP_DEPTH) cap_state = prbs_emu_pkg::CAP_DONE;
                end
                for (int i = 0; i < `NTI; i++) begin
                    model_q[i] = {model_q[i][`PRBS_N-2:0], ^(model_q[i] & eqn_i)};
                end
            end
            // Start only counts when idle
            if (dump_start_i && cap_state == prbs_emu_pkg::CAP_IDLE) begin
                cap_state = prbs_emu_pkg::CAP_FILL;
            end
        end
    end

    ////////////////////
    // Commands
    ////////////////////

    task automatic read_words(int first, int count, int collide);
        int addr;
        int gap;
        int lat;
        for (int k = 0; k < count; k++) begin
            addr = first + k;
            if (addr >= dump_cnt) begin
                $display("Trace reads address %0d before it was captured", addr);
                stop_on_failure();
            end
            if (collide != 0) begin
                // Land the read strobe on the next stream strobe
                @(negedge emu_clk);
                while (!word_stb_o) @(negedge emu_clk);
                repeat (`NUM_CHUNKS + 1) @(posedge emu_clk);
            end else begin
                gap = int'($urandom % 4);
                repeat (gap) @(posedge emu_clk);
            end
            @(posedge emu_clk);
            rd_stb_i  <= 1'b1;
            rd_addr_i <= `DUMP_AW'(addr);
            @(posedge emu_clk);
            rd_stb_i <= 1'b0;
            lat = 1;
            @(negedge emu_clk);
            while (!rd_valid_o && lat < 3) begin
                @(posedge emu_clk);
                lat++;
                @(negedge emu_clk);
            end
            if (!rd_valid_o) begin
                $display("Read of address %0d returned no data within 3 cycles", addr);
                stop_on_failure();
            end
            if (collide != 0) check_value("read latency", lat, 3);
            check_value("rd_data_o", 32'(rd_data_o), 32'(dump_exp[addr]));
        end
    endtask

    task automatic run_command(int c);
        string op;
        op = op_q[c];
        if (op == "wait") begin
            repeat (arg0_q[c]) @(posedge emu_clk);
        end else if (op == "mask") begin
            @(posedge emu_clk);
            inj_mask_i <= prbs_emu_pkg::lane_word_t'(arg0_q[c]);
        end else if (op == "pol") begin
            @(posedge emu_clk);
            polarity_i <= prbs_emu_pkg::polarity_e'(arg0_q[c][0]);
        end else if (op == "dump") begin
            @(posedge emu_clk);
            dump_start_i <= 1'b1;
            @(posedge emu_clk);
            dump_start_i <= 1'b0;
        end else if (op == "done") begin
            @(negedge emu_clk);
            check_value("dump_done_o", 32'(dump_done_o), arg0_q[c]);
        end else if (op == "read") begin
            read_words(arg0_q[c], arg1_q[c], arg2_q[c]);
        end else begin
            $display("Unknown trace command %s", op);
            stop_on_failure();
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(74652));
        emu_rst      <= 1'b1;
        inj_mask_i   <= '0;
        polarity_i   <= prbs_emu_pkg::POL_NORMAL;
        dump_start_i <= 1'b0;
        rd_stb_i     <= 1'b0;
        rd_addr_i    <= '0;
        eqn_i        <= '0;
        load_trace();
        for (int i = 0; i < `NTI; i++) begin
            seeds_i[i] <= seed_val[i];
        end
        repeat (10) @(posedge emu_clk);
        emu_rst <= 1'b0;
        // Outputs quiet right after reset
        @(negedge emu_clk);
        check_value("word_stb_o", 32'(word_stb_o), 32'h0);
        check_value("rd_valid_o", 32'(rd_valid_o), 32'h0);
        for (int c = 0; c < op_q.size(); c++) begin
            run_command(c);
        end
        repeat (4) @(posedge emu_clk);
        if (dump_cnt == `DUMP_DEPTH) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Dump capture recorded %0d words instead of %0d", dump_cnt, `DUMP_DEPTH);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: prbs_emu_trace.txt
# eqn <hex taps> | seed <lane> <hex state> | wait <cycles> | mask <hex lanes> | pol <0|1>
# dump | done <expected dump_done_o> | read <first addr> <count> <align to strobe 0|1>
eqn 80200003
seed 0 00000001
seed 1 8badf00d
seed 2 12345678
seed 3 9a4c11f0
seed 4 0f0f0f0f
seed 5 deadbeef
seed 6 13579bdf
seed 7 2468ace0
seed 8 7fffffff
seed 9 a5a5a5a5
seed 10 5a5a5a5a
seed 11 c0ffee11
seed 12 0badcafe
seed 13 fedcba98
seed 14 31415926
seed 15 27182818
wait 60
mask 0005
wait 24
mask 0000
wait 24
pol 1
wait 30
pol 0
wait 12
dump
wait 30
dump
done 0
wait 24
read 0 4 1
mask 8001
wait 12
mask 0000
wait 150
done 1
read 0 32 0
wait 12

// File: compile.f
+incdir+.
prbs_emu_pkg.sv
prbs_lane_gen.sv
prbs_source_bank.sv
dump_capture.sv
dump_reader.sv
sram_arbiter.sv
dump_sram.sv
prbs_emu_top.sv
tb_prbs_emu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grep the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_prbs_emu -f compile.f -o sim_prbs_emu \
    && ./obj_dir/sim_prbs_emu > sim.log 2>&1 \
    || echo "Build or simulation reported an error"

cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
